// ==== bench/mem_model.sv ====
`default_nettype none

module mem_model #(
	parameter int LINES = 256
) (
	input  wire                   clk,
	input  wire                   rst_n_i,
	input  wire                   mem_cs_i,
	input  wire                   mem_we_i,
	input  wire [31:0]            mem_addr_i,
	input  wire cache_pkg::line_t mem_wdata_i,
	output cache_pkg::line_t      mem_rdata_o,
	output logic                  mem_ack_o,
	input  wire [3:0]             ack_delay_i,
	output logic [31:0]           rd_count_o,
	output logic [31:0]           wb_count_o,
	output logic [31:0]           last_rd_addr_o,
	output logic [31:0]           last_wb_addr_o
);

	import cache_pkg::*;

	localparam int LINE_SEL_W = $clog2(LINES);

	line_t lines [0:LINES-1];
	logic [3:0] wait_cnt;
	logic [LINE_SEL_W-1:0] line_sel;

	assign line_sel = mem_addr_i[OFFSET_W +: LINE_SEL_W];

	// each word holds its own byte address xor a fixed marker
	initial begin
		for (int l = 0; l < LINES; l++) begin
			for (int w = 0; w < LINE_WORDS; w++) begin
				lines[l][w*WORD_W +: WORD_W] = 32'(l * 32 + w * 4) ^ 32'h5a5a0000;
			end
		end
	end

	// ack rises ack_delay_i cycles after the request and lasts one cycle
	always @(posedge clk) begin
		if (!rst_n_i) begin
			mem_ack_o <= 1'b0;
			wait_cnt <= '0;
			rd_count_o <= '0;
			wb_count_o <= '0;
			last_rd_addr_o <= '0;
			last_wb_addr_o <= '0;
		end else if (mem_ack_o) begin
			mem_ack_o <= 1'b0;
			wait_cnt <= '0;
		end else if (mem_cs_i) begin
			if (wait_cnt >= ack_delay_i) begin
				mem_ack_o <= 1'b1;
				wait_cnt <= '0;
				if (mem_we_i) begin
					lines[line_sel] <= mem_wdata_i;
					wb_count_o <= wb_count_o + 32'd1;
					last_wb_addr_o <= mem_addr_i;
				end else begin
					mem_rdata_o <= lines[line_sel];
					rd_count_o <= rd_count_o + 32'd1;
					last_rd_addr_o <= mem_addr_i;
				end
			end else begin
				wait_cnt <= wait_cnt + 4'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== bench/tb_l1_cache.sv ====
`default_nettype none

module tb_l1_cache;

	import cache_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int MEM_LINES = 256;
	localparam int RANDOM_OPS = 200;
	localparam int NUM_ACCESSES = 12 + RANDOM_OPS;
	// writeback and fill at the longest delay, plus idle, two lookups and complete
	localparam int WORST_MISS = 2 * (5 + 2) + 4;
	localparam int TIMEOUT = (NUM_ACCESSES * WORST_MISS + 100) * CLK_PERIOD;

	logic clk;
	logic rst_n;
	logic cs;
	logic we;
	word_t addr;
	word_t wdata;
	word_t rdata;
	logic stall;
	logic mem_cs;
	logic mem_we;
	logic [ADDR_W-1:0] mem_addr;
	line_t mem_wdata;
	line_t mem_rdata;
	logic mem_ack;
	logic [3:0] ack_delay;
	logic [31:0] rd_count;
	logic [31:0] wb_count;
	logic [31:0] last_rd_addr;
	logic [31:0] last_wb_addr;

	word_t ref_mem [0:MEM_LINES*LINE_WORDS-1];

	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;

	always #(CLK_PERIOD / 2) clk = ~clk;

	l1_cache dut (
		.clk         (clk),
		.rst_n_i     (rst_n),
		.cs_i        (cs),
		.we_i        (we),
		.addr_i      (addr),
		.wdata_i     (wdata),
		.rdata_o     (rdata),
		.stall_o     (stall),
		.mem_cs_o    (mem_cs),
		.mem_we_o    (mem_we),
		.mem_addr_o  (mem_addr),
		.mem_wdata_o (mem_wdata),
		.mem_rdata_i (mem_rdata),
		.mem_ack_i   (mem_ack)
	);

	mem_model #(
		.LINES (MEM_LINES)
	) mem (
		.clk            (clk),
		.rst_n_i        (rst_n),
		.mem_cs_i       (mem_cs),
		.mem_we_i       (mem_we),
		.mem_addr_i     (mem_addr),
		.mem_wdata_i    (mem_wdata),
		.mem_rdata_o    (mem_rdata),
		.mem_ack_o      (mem_ack),
		.ack_delay_i    (ack_delay),
		.rd_count_o     (rd_count),
		.wb_count_o     (wb_count),
		.last_rd_addr_o (last_rd_addr),
		.last_wb_addr_o (last_wb_addr)
	);

	// one processor access, cycles counts from cs rising to the completing cycle
	task automatic access_word(input logic is_write, input word_t a, input word_t d,
			output word_t rd, output int cycles);
		@(negedge clk);
		cs = 1'b1;
		we = is_write;
		addr = a;
		wdata = d;
		cycles = 1;
		do begin
			@(negedge clk);
			cycles++;
		end while (stall);
		rd = rdata;
		if (is_write) begin
			ref_mem[a[12:2]] = d;
		end
	endtask

	task automatic show_mismatch(input string name, input word_t exp, input word_t act);
		$display("MISMATCH %s: expected %08h, actual %08h", name, exp, act);
		test_errors++;
	endtask

	task automatic note_failure(input string msg);
		$display("ERROR %s", msg);
		test_errors++;
	endtask

	task automatic close_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d error(s)", name, test_errors);
			tests_failed++;
			errors += test_errors;
		end
		test_errors = 0;
	endtask

	task automatic cold_read_miss();
		word_t rd;
		int cycles;
		logic [31:0] rd_before;
		if (stall !== 1'b0 || mem_cs !== 1'b0) begin
			note_failure("stall or memory request is active right after reset");
		end
		ack_delay = 4'd2;
		rd_before = rd_count;
		access_word(1'b0, 32'h0000_0124, '0, rd, cycles);
		if (cycles <= 2) begin
			note_failure("cold read completed without stalling");
		end
		if (rd_count - rd_before != 32'd1) begin
			note_failure("cold read did not issue exactly one memory read");
		end
		if (last_rd_addr !== 32'h0000_0120) begin
			show_mismatch("cold_read_miss address", 32'h0000_0120, last_rd_addr);
		end
		if (rd !== ref_mem[11'h049]) begin
			show_mismatch("cold_read_miss data", ref_mem[11'h049], rd);
		end
		close_test("cold_read_miss");
	endtask

	task automatic same_line_hit();
		word_t rd;
		int cycles;
		logic [31:0] rd_before;
		logic [31:0] wb_before;
		rd_before = rd_count;
		wb_before = wb_count;
		access_word(1'b0, 32'h0000_0138, '0, rd, cycles);
		if (cycles != 2) begin
			show_mismatch("same_line_hit cycles", 32'd2, 32'(cycles));
		end
		if (rd_count != rd_before || wb_count != wb_before) begin
			note_failure("read hit caused a memory request");
		end
		if (rd !== ref_mem[11'h04e]) begin
			show_mismatch("same_line_hit data", ref_mem[11'h04e], rd);
		end
		close_test("same_line_hit");
	endtask

	task automatic write_hit_readback();
		word_t rd;
		int cycles;
		logic [31:0] rd_before;
		logic [31:0] wb_before;
		rd_before = rd_count;
		wb_before = wb_count;
		access_word(1'b1, 32'h0000_0128, 32'hcafe_f00d, rd, cycles);
		access_word(1'b0, 32'h0000_0128, '0, rd, cycles);
		if (rd !== ref_mem[11'h04a]) begin
			show_mismatch("write_hit_readback written word", ref_mem[11'h04a], rd);
		end
		access_word(1'b0, 32'h0000_012c, '0, rd, cycles);
		if (rd !== ref_mem[11'h04b]) begin
			show_mismatch("write_hit_readback neighbor", ref_mem[11'h04b], rd);
		end
		if (rd_count != rd_before || wb_count != wb_before) begin
			note_failure("write hit caused a memory request");
		end
		close_test("write_hit_readback");
	endtask

	task automatic dirty_eviction();
		word_t rd;
		int cycles;
		logic [31:0] wb_before;
		ack_delay = 4'd3;
		wb_before = wb_count;
		// tag 1 at the same index as the dirty line at 0x120
		access_word(1'b0, 32'h0000_0528, '0, rd, cycles);
		if (rd !== ref_mem[11'h14a]) begin
			show_mismatch("dirty_eviction new line", ref_mem[11'h14a], rd);
		end
		if (wb_count - wb_before != 32'd1) begin
			note_failure("eviction of a dirty line did not write back exactly once");
		end
		if (last_wb_addr !== 32'h0000_0120) begin
			show_mismatch("dirty_eviction writeback address", 32'h0000_0120, last_wb_addr);
		end
		if (mem.lines[9][2*WORD_W +: WORD_W] !== 32'hcafe_f00d) begin
			show_mismatch("dirty_eviction memory word", 32'hcafe_f00d,
				mem.lines[9][2*WORD_W +: WORD_W]);
		end
		access_word(1'b0, 32'h0000_0128, '0, rd, cycles);
		if (rd !== ref_mem[11'h04a]) begin
			show_mismatch("dirty_eviction reread", ref_mem[11'h04a], rd);
		end
		if (wb_count - wb_before != 32'd1) begin
			note_failure("evicting a clean line wrote it back");
		end
		close_test("dirty_eviction");
	endtask

	task automatic random_traffic();
		word_t a;
		word_t d;
		word_t exp;
		word_t rd;
		logic is_write;
		int cycles;
		for (int n = 0; n < RANDOM_OPS; n++) begin
			// four tags over four indices keep evicting each other
			a = {20'd0, 2'($urandom), 5'($urandom_range(0, 3)), 3'($urandom), 2'b00};
			d = $urandom;
			is_write = 1'($urandom);
			ack_delay = 4'($urandom_range(0, 5));
			exp = ref_mem[a[12:2]];
			access_word(is_write, a, d, rd, cycles);
			if (!is_write && rd !== exp) begin
				show_mismatch($sformatf("random_traffic read %08h", a), exp, rd);
			end
		end
		close_test("random_traffic");
	endtask

	initial begin
		#(TIMEOUT);
		$display("watchdog expired, the cache stopped completing accesses");
		$display("Done: errors found");
		$finish;
	end

	initial begin
		void'($urandom(32'hb50a));
		clk = 1'b0;
		rst_n = 1'b0;
		cs = 1'b0;
		we = 1'b0;
		addr = '0;
		wdata = '0;
		ack_delay = 4'd0;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		for (int i = 0; i < MEM_LINES * LINE_WORDS; i++) begin
			ref_mem[i] = 32'(i * 4) ^ 32'h5a5a0000;
		end
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		cold_read_miss();
		same_line_hit();
		write_hit_readback();
		dirty_eviction();
		random_traffic();

		@(negedge clk);
		cs = 1'b0;
		repeat (2) @(negedge clk);
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

	// processor side
	localparam int ADDR_W = 32;
	localparam int WORD_W = 32;

	// line geometry
	localparam int LINE_WORDS = 8;
	localparam int LINE_W = LINE_WORDS * WORD_W;

	// address split is tag | index | byte offset
	localparam int OFFSET_W = 5;
	localparam int INDEX_W = 5;
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [WORD_W-1:0] word_t;

	// word 0 sits in bits 31:0
	typedef logic [LINE_W-1:0] line_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WRITEBACK,
		FILL,
		COMPLETE
	} ctrl_state_t;

endpackage

`default_nettype wire

// ==== hw/l1_cache.sv ====
`default_nettype none

module l1_cache (
	input  wire                          clk,
	input  wire                          rst_n_i,
	input  wire                          cs_i,
	input  wire                          we_i,
	input  wire  [cache_pkg::ADDR_W-1:0] addr_i,
	input  wire  [cache_pkg::WORD_W-1:0] wdata_i,
	output logic [cache_pkg::WORD_W-1:0] rdata_o,
	output logic                         stall_o,
	output logic                         mem_cs_o,
	output logic                         mem_we_o,
	output logic [cache_pkg::ADDR_W-1:0] mem_addr_o,
	output cache_pkg::line_t             mem_wdata_o,
	input  wire  cache_pkg::line_t       mem_rdata_i,
	input  wire                          mem_ack_i
);

	import cache_pkg::*;

	localparam int LINES = 2 ** INDEX_W;
	localparam int WSEL_W = $clog2(LINE_WORDS);

	tag_t              req_tag;
	index_t            req_index;
	logic [WSEL_W-1:0] word_sel;

	tag_t  tag_rdata;
	line_t line_rdata;
	line_t line_wdata;
	line_t merged_line;

	logic [LINES-1:0] valid_q;
	logic [LINES-1:0] dirty_q;

	logic hit;
	logic line_dirty;

	logic sram_cs;
	logic sram_we;
	logic fill_sel;
	logic set_valid;
	logic set_dirty;
	logic clear_dirty;

	// address fields
	assign req_tag = addr_i[ADDR_W-1 -: TAG_W];
	assign req_index = addr_i[OFFSET_W +: INDEX_W];
	assign word_sel = addr_i[OFFSET_W-1 -: WSEL_W];

	assign hit = valid_q[req_index] && (tag_rdata == req_tag);
	assign line_dirty = dirty_q[req_index];

	// read word out of the current line
	assign rdata_o = line_rdata[word_sel*WORD_W +: WORD_W];

	// write hit keeps the line and replaces the addressed word
	always_comb begin
		merged_line = line_rdata;
		merged_line[word_sel*WORD_W +: WORD_W] = wdata_i;
	end

	assign line_wdata = fill_sel ? mem_rdata_i : merged_line;

	// writeback goes to the victim's address, fill to the requested one
	assign mem_addr_o = mem_we_o ? {tag_rdata, req_index, {OFFSET_W{1'b0}}}
		: {req_tag, req_index, {OFFSET_W{1'b0}}};
	assign mem_wdata_o = line_rdata;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			if (set_valid) begin
				valid_q[req_index] <= 1'b1;
			end
			if (set_dirty) begin
				dirty_q[req_index] <= 1'b1;
			end else if (clear_dirty) begin
				dirty_q[req_index] <= 1'b0;
			end
		end
	end

	l1_cache_controller controller (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.cs_i          (cs_i),
		.we_i          (we_i),
		.hit_i         (hit),
		.dirty_i       (line_dirty),
		.mem_ack_i     (mem_ack_i),
		.stall_o       (stall_o),
		.sram_cs_o     (sram_cs),
		.sram_we_o     (sram_we),
		.fill_sel_o    (fill_sel),
		.set_valid_o   (set_valid),
		.set_dirty_o   (set_dirty),
		.clear_dirty_o (clear_dirty),
		.mem_cs_o      (mem_cs_o),
		.mem_we_o      (mem_we_o)
	);

	// tag is rewritten on every store, unchanged on a hit
	sram_sp #(
		.DEPTH   (LINES),
		.entry_t (tag_t)
	) tag_mem (
		.clk     (clk),
		.cs_i    (sram_cs),
		.we_i    (sram_we),
		.addr_i  (req_index),
		.wdata_i (req_tag),
		.rdata_o (tag_rdata)
	);

	sram_sp #(
		.DEPTH   (LINES),
		.entry_t (line_t)
	) data_mem (
		.clk     (clk),
		.cs_i    (sram_cs),
		.we_i    (sram_we),
		.addr_i  (req_index),
		.wdata_i (line_wdata),
		.rdata_o (line_rdata)
	);

	// every completing access must see a hit with memory idle
	a_complete_hit: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		(cs_i && !stall_o) |-> (hit && !mem_cs_o)
	);

endmodule

`default_nettype wire

// ==== hw/l1_cache_controller.sv ====
`default_nettype none

module l1_cache_controller (
	input  wire  clk,
	input  wire  rst_n_i,
	input  wire  cs_i,
	input  wire  we_i,
	input  wire  hit_i,
	input  wire  dirty_i,
	input  wire  mem_ack_i,
	output logic stall_o,
	output logic sram_cs_o,
	output logic sram_we_o,
	output logic fill_sel_o,
	output logic set_valid_o,
	output logic set_dirty_o,
	output logic clear_dirty_o,
	output logic mem_cs_o,
	output logic mem_we_o
);

	import cache_pkg::*;

	ctrl_state_t state_q;
	ctrl_state_t state_d;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		stall_o = 1'b0;
		sram_cs_o = 1'b0;
		sram_we_o = 1'b0;
		fill_sel_o = 1'b0;
		set_valid_o = 1'b0;
		set_dirty_o = 1'b0;
		clear_dirty_o = 1'b0;
		mem_cs_o = 1'b0;
		mem_we_o = 1'b0;

		case (state_q)
			IDLE: begin
				// new request reads tag and line at the index
				if (cs_i) begin
					stall_o = 1'b1;
					sram_cs_o = 1'b1;
					state_d = LOOKUP;
				end
			end
			LOOKUP: begin
				if (hit_i) begin
					// hit completes here and a write stores the merged line
					sram_cs_o = we_i;
					sram_we_o = we_i;
					set_dirty_o = we_i;
					state_d = IDLE;
				end else begin
					stall_o = 1'b1;
					state_d = dirty_i ? WRITEBACK : FILL;
				end
			end
			WRITEBACK: begin
				stall_o = 1'b1;
				mem_cs_o = 1'b1;
				mem_we_o = 1'b1;
				// victim is clean now so the second lookup goes on to FILL
				if (mem_ack_i) begin
					clear_dirty_o = 1'b1;
					state_d = LOOKUP;
				end
			end
			FILL: begin
				stall_o = 1'b1;
				mem_cs_o = 1'b1;
				// refill line and tag while the SRAM output picks up the new entry
				if (mem_ack_i) begin
					sram_cs_o = 1'b1;
					sram_we_o = 1'b1;
					fill_sel_o = 1'b1;
					set_valid_o = 1'b1;
					state_d = COMPLETE;
				end
			end
			COMPLETE: begin
				sram_cs_o = we_i;
				sram_we_o = we_i;
				set_dirty_o = we_i;
				state_d = IDLE;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	// memory request drops in the cycle after its acknowledge
	a_mem_drop: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		(mem_cs_o && mem_ack_i) |=> !mem_cs_o
	);

	// request has to stay put until memory acknowledges it
	a_mem_hold: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		(mem_cs_o && !mem_ack_i) |=> (mem_cs_o && $stable(mem_we_o))
	);

endmodule

`default_nettype wire

// ==== hw/sram_sp.sv ====
`default_nettype none

module sram_sp #(
	parameter int  DEPTH   = 32,
	parameter type entry_t = logic [31:0]
) (
	input  wire                     clk,
	input  wire                     cs_i,
	input  wire                     we_i,
	input  wire [$clog2(DEPTH)-1:0] addr_i,
	input  wire entry_t             wdata_i,
	output entry_t                  rdata_o
);

	entry_t mem [0:DEPTH-1];

	// registered read, one access per cycle
	// a write also returns the stored entry on rdata_o, so the cycle
	// that writes a refilled line leaves it on the output for the next cycle
	always_ff @(posedge clk) begin
		if (cs_i) begin
			if (we_i) begin
				mem[addr_i] <= wdata_i;
				rdata_o <= wdata_i;
			end else begin
				rdata_o <= mem[addr_i];
			end
		end
	end

	// index comes straight from the processor address
	a_addr_known: assert property (
		@(posedge clk) cs_i |-> !$isunknown(addr_i)
	);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_l1_cache \
	-f verilog.f --Mdir obj_dir -o tb_l1_cache > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_l1_cache > sim.log 2>&1

grep -qx "Done: no errors" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }

// ==== verilog.f ====
hw/cache_pkg.sv
hw/sram_sp.sv
hw/l1_cache_controller.sv
hw/l1_cache.sv
bench/mem_model.sv
bench/tb_l1_cache.sv
